// ==== files.f ====
+incdir+include
hw/tmr_cfg_pkg.sv
hw/tmr_regmap_pkg.sv
hw/tmr_bus_fsm.sv
hw/tmr_prescaler.sv
hw/tmr_downcounter.sv
hw/tmr_regs.sv
hw/prog_timer_top.sv
sim/prog_timer_tb.sv

// ==== Bender.yml ====
package:
  name: prog_timer

sources:
  - files:
      - hw/tmr_cfg_pkg.sv
      - hw/tmr_regmap_pkg.sv
      - hw/tmr_bus_fsm.sv
      - hw/tmr_prescaler.sv
      - hw/tmr_downcounter.sv
      - hw/tmr_regs.sv
      - hw/prog_timer_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/prog_timer_tb.sv

// ==== include/tmr_tb_tasks.svh ====
`ifndef TMR_TB_TASKS_SVH
`define TMR_TB_TASKS_SVH

// Compare and count a mismatch
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp)
    else begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        error_count++;
    end
endtask

// One bus access, response held off for stall cycles
task automatic bus_access(input logic write, input tmr_regmap_pkg::addr_t addr,
                          input tmr_regmap_pkg::nibble_t wdata, input int stall,
                          output tmr_regmap_pkg::nibble_t rdata);
    tmr_regmap_pkg::nibble_t first_rdata;
    @(negedge clk);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    while (!req_ready) @(negedge clk);
    @(negedge clk); // Accepted on the edge just passed
    req_valid = 1'b0;
    while (!rsp_valid) @(negedge clk);
    first_rdata = rsp_rdata;
    repeat (stall) begin
        @(negedge clk);
        check_value("rsp_valid", rsp_valid, 1'b1);
        check_value("rsp_rdata", rsp_rdata, first_rdata);
        check_value("req_ready", req_ready, 1'b0);
    end
    rsp_ready = 1'b1;
    rdata     = rsp_rdata;
    @(negedge clk);
    rsp_ready = 1'b0;
endtask

task automatic bus_write(input tmr_regmap_pkg::addr_t addr,
                         input tmr_regmap_pkg::nibble_t wdata);
    tmr_regmap_pkg::nibble_t unused_rdata;
    bus_access(1'b1, addr, wdata, 0, unused_rdata);
    check_value("write rsp_rdata", unused_rdata, 4'h0);
endtask

task automatic bus_read(input tmr_regmap_pkg::addr_t addr,
                        output tmr_regmap_pkg::nibble_t rdata);
    bus_access(1'b0, addr, 4'h0, 0, rdata);
endtask

`endif

// ==== sim/prog_timer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_timer_tb;

    localparam int unsigned COUNT_WIDTH = 8;
    // Two expiries of reload 40 at select 4
    localparam int LONGEST_TEST_CYCLES = 2 * 40 * (128 >> (4 - 2));
    localparam int TIMEOUT_CYCLES = 3 * (LONGEST_TEST_CYCLES + 400); // Plus bus traffic

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    logic                    req_ready;
    logic                    req_write;
    tmr_regmap_pkg::addr_t   req_addr;
    tmr_regmap_pkg::nibble_t req_wdata;
    logic                    rsp_valid;
    logic                    rsp_ready;
    tmr_regmap_pkg::nibble_t rsp_rdata;
    logic                    irq;

    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;
    integer seed;

    `include "tmr_tb_tasks.svh"

    prog_timer_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) prog_timer_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .irq       (irq)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // irq has settled by the falling edge
    task automatic wait_irq_high(output int at_cycle);
        @(negedge clk);
        while (irq !== 1'b1) @(negedge clk);
        at_cycle = cycle_count;
    endtask

    task automatic read_count(output logic [7:0] value);
        tmr_regmap_pkg::nibble_t lo;
        tmr_regmap_pkg::nibble_t hi;
        bus_read(tmr_regmap_pkg::ADDR_COUNT_LO, lo);
        bus_read(tmr_regmap_pkg::ADDR_COUNT_HI, hi);
        value = {hi, lo};
    endtask

    task automatic check_below(input string name, input logic [7:0] got, input logic [7:0] limit);
        assert (got < limit)
        else begin
            $display("[ERROR] %s: got 0x%0h, expected below 0x%0h", name, got, limit);
            error_count++;
        end
    endtask

    // Stop, clear a pending factor, load the setup, then restart and enable
    task automatic setup_timer(input logic [7:0] reload, input tmr_cfg_pkg::clock_sel_t sel,
                               input logic mask);
        tmr_regmap_pkg::nibble_t unused_rdata;
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h0);
        bus_read(tmr_regmap_pkg::ADDR_FACTOR, unused_rdata);
        bus_write(tmr_regmap_pkg::ADDR_RELOAD_LO, reload[3:0]);
        bus_write(tmr_regmap_pkg::ADDR_RELOAD_HI, reload[7:4]);
        bus_write(tmr_regmap_pkg::ADDR_CLKSEL, {1'b0, sel});
        bus_write(tmr_regmap_pkg::ADDR_MASK, {3'b000, mask});
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h3);
    endtask

    task automatic run_round_trip();
        int                      errors_before;
        tmr_regmap_pkg::nibble_t wval [4];
        tmr_regmap_pkg::nibble_t rval;
        tmr_regmap_pkg::addr_t   addrs [4];
        errors_before = error_count;
        addrs = '{tmr_regmap_pkg::ADDR_RELOAD_LO, tmr_regmap_pkg::ADDR_RELOAD_HI,
                  tmr_regmap_pkg::ADDR_MASK, tmr_regmap_pkg::ADDR_CLKSEL};
        check_value("req_ready", req_ready, 1'b1);
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("irq", irq, 1'b0);
        foreach (addrs[i]) begin
            bus_read(addrs[i], rval);
            check_value("rsp_rdata after reset", rval, 4'h0);
            wval[i] = 4'($random(seed));
            bus_write(addrs[i], wval[i]);
        end
        bus_read(tmr_regmap_pkg::ADDR_RELOAD_LO, rval);
        check_value("rsp_rdata (reload lo)", rval, wval[0]);
        bus_read(tmr_regmap_pkg::ADDR_RELOAD_HI, rval);
        check_value("rsp_rdata (reload hi)", rval, wval[1]);
        bus_read(tmr_regmap_pkg::ADDR_MASK, rval);
        check_value("rsp_rdata (mask)", rval, {3'b000, wval[2][0]});
        bus_read(tmr_regmap_pkg::ADDR_CLKSEL, rval);
        check_value("rsp_rdata (clock select)", rval, wval[3]);
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h2); // Restart only
        bus_read(tmr_regmap_pkg::ADDR_COUNT_LO, rval);
        check_value("rsp_rdata (count lo)", rval, wval[0]);
        end_test("Register round trip", errors_before);
    endtask

    task automatic run_tick_rates();
        int                      errors_before;
        int                      first_edge;
        int                      second_edge;
        int                      period;
        tmr_regmap_pkg::nibble_t rval;
        errors_before = error_count;
        for (int sel = 2; sel <= 7; sel++) begin
            period = 128 >> (sel - 2); // 128 cycles at select 2, halved per step
            setup_timer(8'd2, tmr_cfg_pkg::clock_sel_t'(sel), 1'b1);
            wait_irq_high(first_edge);
            bus_read(tmr_regmap_pkg::ADDR_FACTOR, rval);
            check_value("rsp_rdata (factor)", rval, 4'h1);
            check_value("irq after factor read", irq, 1'b0);
            wait_irq_high(second_edge);
            check_value("irq edge spacing", second_edge - first_edge, 2 * period);
            bus_read(tmr_regmap_pkg::ADDR_FACTOR, rval);
        end
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h0);
        end_test("Tick rates", errors_before);
    endtask

    task automatic run_pause_resume();
        int         errors_before;
        logic [7:0] frozen;
        logic [7:0] later;
        errors_before = error_count;
        setup_timer(8'd200, 3'd5, 1'b0); // Period 16
        repeat (4 * 16) @(negedge clk);
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h0);
        read_count(frozen);
        check_below("count after running", frozen, 8'd200);
        repeat (8 * 16) @(negedge clk);
        read_count(later);
        check_value("count while paused", later, frozen);
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h1); // Resume without restart
        repeat (4 * 16) @(negedge clk);
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h0);
        read_count(later);
        check_below("count after resume", later, frozen);
        end_test("Pause and resume", errors_before);
    endtask

    task automatic run_mask_clear();
        int                      errors_before;
        logic                    irq_seen;
        tmr_regmap_pkg::nibble_t rval;
        errors_before = error_count;
        irq_seen = 1'b0;
        setup_timer(8'd40, 3'd4, 1'b0);
        repeat (LONGEST_TEST_CYCLES) begin
            @(negedge clk);
            if (irq !== 1'b0) irq_seen = 1'b1;
        end
        check_value("irq with mask 0", irq_seen, 1'b0);
        bus_write(tmr_regmap_pkg::ADDR_CTRL, 4'h0);
        bus_read(tmr_regmap_pkg::ADDR_FACTOR, rval);
        check_value("rsp_rdata (factor first read)", rval, 4'h1);
        bus_read(tmr_regmap_pkg::ADDR_FACTOR, rval);
        check_value("rsp_rdata (factor second read)", rval, 4'h0);
        end_test("Mask gating and clear on read", errors_before);
    endtask

    task automatic run_back_pressure();
        int                      errors_before;
        int                      stall;
        tmr_regmap_pkg::nibble_t wval;
        tmr_regmap_pkg::nibble_t rval;
        errors_before = error_count;
        for (int i = 0; i < 4; i++) begin
            wval  = 4'($random(seed));
            stall = 2 + ({$random(seed)} % 12);
            bus_access(1'b1, tmr_regmap_pkg::ADDR_RELOAD_LO, wval, stall, rval);
            check_value("write rsp_rdata", rval, 4'h0);
            check_value("req_ready after response", req_ready, 1'b1);
            stall = 2 + ({$random(seed)} % 12);
            bus_access(1'b0, tmr_regmap_pkg::ADDR_RELOAD_LO, 4'h0, stall, rval);
            check_value("rsp_rdata (reload lo)", rval, wval);
        end
        end_test("Handshake back-pressure", errors_before);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        rsp_ready    = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        seed         = 32'h8ff;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        run_round_trip();
        run_tick_rates();
        run_pause_resume();
        run_mask_clear();
        run_back_pressure();
        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/prog_timer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_timer_top #(
    parameter int unsigned COUNT_WIDTH = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire logic                    req_valid,
    output logic                         req_ready,
    input  wire logic                    req_write,
    input  wire tmr_regmap_pkg::addr_t   req_addr,
    input  wire tmr_regmap_pkg::nibble_t req_wdata,

    output logic                         rsp_valid,
    input  wire logic                    rsp_ready,
    output tmr_regmap_pkg::nibble_t      rsp_rdata,

    output logic                         irq
);

    // Bus FSM to register file
    logic                    rd_stb;
    logic                    wr_stb;
    tmr_regmap_pkg::addr_t   reg_addr;
    tmr_regmap_pkg::nibble_t reg_wdata;
    tmr_regmap_pkg::nibble_t rd_data;

    // Register file to timing chain and back
    tmr_cfg_pkg::clock_sel_t clock_sel;
    logic                    enable;
    logic                    restart;
    logic [COUNT_WIDTH-1:0]  reload;
    logic [COUNT_WIDTH-1:0]  count;
    logic                    expire;
    logic                    tick;

    tmr_bus_fsm bus_fsm_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rd_stb    (rd_stb),
        .wr_stb    (wr_stb),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .rd_data   (rd_data)
    );

    tmr_regs #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_stb    (rd_stb),
        .wr_stb    (wr_stb),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .rd_data   (rd_data),
        .count     (count),
        .expire    (expire),
        .clock_sel (clock_sel),
        .enable    (enable),
        .restart   (restart),
        .reload    (reload),
        .irq       (irq)
    );

    tmr_prescaler prescaler_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .restart   (restart),
        .clock_sel (clock_sel),
        .tick      (tick)
    );

    tmr_downcounter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) downcounter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .restart (restart),
        .reload  (reload),
        .count   (count),
        .expire  (expire)
    );

endmodule

`default_nettype wire

// ==== hw/tmr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmr_regs #(
    parameter int unsigned COUNT_WIDTH = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire logic                    rd_stb,
    input  wire logic                    wr_stb,
    input  wire tmr_regmap_pkg::addr_t   reg_addr,
    input  wire tmr_regmap_pkg::nibble_t reg_wdata,
    output tmr_regmap_pkg::nibble_t      rd_data,

    input  wire logic [COUNT_WIDTH-1:0]  count,
    input  wire logic                    expire,

    output tmr_cfg_pkg::clock_sel_t      clock_sel,
    output logic                         enable,
    output logic                         restart,
    output logic      [COUNT_WIDTH-1:0]  reload,
    output logic                         irq
);

    tmr_regmap_pkg::nibble_t clksel_q; // All four bits read back
    logic                    mask_q;
    logic                    factor_q;

    // Counter and reload seen as two nibbles
    logic [7:0] count_wide;
    logic [7:0] reload_wide;

    logic wr_ctrl;
    logic rd_factor;

    assign count_wide  = 8'(count);
    assign reload_wide = 8'(reload);

    assign wr_ctrl   = wr_stb && (reg_addr == tmr_regmap_pkg::ADDR_CTRL);
    assign rd_factor = rd_stb && (reg_addr == tmr_regmap_pkg::ADDR_FACTOR);

    // One-cycle pulse, in the same cycle as the write strobe
    assign restart = wr_ctrl && reg_wdata[tmr_regmap_pkg::CTRL_RESTART_BIT];

    assign clock_sel = clksel_q[2:0];
    assign irq       = factor_q && mask_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reload   <= '0;
            mask_q   <= 1'b0;
            enable   <= 1'b0;
            clksel_q <= '0;
        end else if (wr_stb) begin
            case (reg_addr)
                tmr_regmap_pkg::ADDR_RELOAD_LO: begin
                    reload <= COUNT_WIDTH'({reload_wide[7:4], reg_wdata});
                end
                tmr_regmap_pkg::ADDR_RELOAD_HI: begin
                    reload <= COUNT_WIDTH'({reg_wdata, reload_wide[3:0]});
                end
                tmr_regmap_pkg::ADDR_MASK:   mask_q   <= reg_wdata[0];
                tmr_regmap_pkg::ADDR_CTRL: begin
                    enable <= reg_wdata[tmr_regmap_pkg::CTRL_ENABLE_BIT];
                end
                tmr_regmap_pkg::ADDR_CLKSEL: clksel_q <= reg_wdata;
                default: ;
            endcase
        end
    end

    // Factor flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            factor_q <= 1'b0;
        end else if (expire) begin
            factor_q <= 1'b1; // Set beats a clearing read
        end else if (rd_factor) begin
            factor_q <= 1'b0;
        end
    end

    always_comb begin
        rd_data = '0; // Unmapped addresses
        case (reg_addr)
            tmr_regmap_pkg::ADDR_FACTOR:    rd_data[0] = factor_q;
            tmr_regmap_pkg::ADDR_MASK:      rd_data[0] = mask_q;
            tmr_regmap_pkg::ADDR_COUNT_LO:  rd_data    = count_wide[3:0];
            tmr_regmap_pkg::ADDR_COUNT_HI:  rd_data    = count_wide[7:4];
            tmr_regmap_pkg::ADDR_RELOAD_LO: rd_data    = reload_wide[3:0];
            tmr_regmap_pkg::ADDR_RELOAD_HI: rd_data    = reload_wide[7:4];
            tmr_regmap_pkg::ADDR_CTRL: begin
                rd_data[tmr_regmap_pkg::CTRL_ENABLE_BIT] = enable;
            end
            tmr_regmap_pkg::ADDR_CLKSEL:    rd_data    = clksel_q;
            default:                        rd_data    = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/tmr_downcounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmr_downcounter #(
    parameter int unsigned COUNT_WIDTH = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   tick,
    input  wire logic                   restart,
    input  wire logic [COUNT_WIDTH-1:0] reload,
    output logic      [COUNT_WIDTH-1:0] count,
    output logic                        expire
);

    logic last_tick; // Count is about to run out

    assign last_tick = (count == COUNT_WIDTH'(1));

    // Restart wins over a coinciding tick
    assign expire = tick && last_tick && !restart;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (restart) begin
            count <= reload;
        end else if (expire) begin
            count <= reload; // Next cycle begins right away
        end else if (tick) begin
            count <= count - COUNT_WIDTH'(1); // Zero wraps to all ones
        end
    end

endmodule

`default_nettype wire

// ==== hw/tmr_prescaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmr_prescaler (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    enable,
    input  wire logic                    restart,
    input  wire tmr_cfg_pkg::clock_sel_t clock_sel,
    output logic                         tick
);

    localparam int unsigned PW = tmr_cfg_pkg::PRESCALE_WIDTH;

    logic [PW-1:0] div_q;
    logic [PW-1:0] period_mask; // Low counter bits spanning one period

    always_comb begin
        period_mask = '0;
        if (clock_sel >= tmr_cfg_pkg::CLOCK_SEL_MIN) begin
            period_mask = PW'((32'd1 << tmr_cfg_pkg::tick_exp(clock_sel)) - 32'd1);
        end
    end

    // Tick on the last count before the low bits wrap
    assign tick = enable
               && (period_mask != '0)
               && ((div_q & period_mask) == period_mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
        end else if (restart) begin
            div_q <= '0; // Next tick one full period away
        end else if (enable) begin
            div_q <= div_q + 1'b1;
        end
        // Held while disabled so a resume continues the period
    end

endmodule

`default_nettype wire

// ==== hw/tmr_bus_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmr_bus_fsm (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire logic                    req_valid,
    output logic                         req_ready,
    input  wire logic                    req_write,
    input  wire tmr_regmap_pkg::addr_t   req_addr,
    input  wire tmr_regmap_pkg::nibble_t req_wdata,

    output logic                         rsp_valid,
    input  wire logic                    rsp_ready,
    output tmr_regmap_pkg::nibble_t      rsp_rdata,

    output logic                         rd_stb,
    output logic                         wr_stb,
    output tmr_regmap_pkg::addr_t        reg_addr,
    output tmr_regmap_pkg::nibble_t      reg_wdata,
    input  wire tmr_regmap_pkg::nibble_t rd_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND
    } state_t;

    state_t state;
    state_t state_next;
    logic   write_q; // Direction of the access in flight
    logic   accept;

    assign accept = req_valid && req_ready;

    // Handshake outputs straight from the state
    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESPOND);

    // One strobe, only in the access state
    assign rd_stb = (state == ST_ACCESS) && !write_q;
    assign wr_stb = (state == ST_ACCESS) && write_q;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = ST_ACCESS;
                end
            end
            ST_ACCESS:  state_next = ST_RESPOND;
            ST_RESPOND: begin
                if (rsp_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request latched at acceptance, held through the access
    always_ff @(posedge clk) begin
        if (accept) begin
            write_q   <= req_write;
            reg_addr  <= req_addr;
            reg_wdata <= req_wdata;
        end
        if (state == ST_ACCESS) begin
            rsp_rdata <= write_q ? '0 : rd_data; // Writes answer with zero
        end
    end

endmodule

`default_nettype wire

// ==== hw/tmr_regmap_pkg.sv ====
`default_nettype none

package tmr_regmap_pkg;

    typedef logic [3:0]  nibble_t; // One bus data unit
    typedef logic [11:0] addr_t;

    // Interrupt factor and mask
    localparam addr_t ADDR_FACTOR    = 12'hF02; // Cleared on read
    localparam addr_t ADDR_MASK      = 12'hF12;

    // Live downcounter value, read only
    localparam addr_t ADDR_COUNT_LO  = 12'hF24;
    localparam addr_t ADDR_COUNT_HI  = 12'hF25;

    localparam addr_t ADDR_RELOAD_LO = 12'hF26;
    localparam addr_t ADDR_RELOAD_HI = 12'hF27;

    localparam addr_t ADDR_CTRL      = 12'hF78;
    localparam addr_t ADDR_CLKSEL    = 12'hF79;

    // Control register fields
    localparam int unsigned CTRL_ENABLE_BIT  = 0;
    localparam int unsigned CTRL_RESTART_BIT = 1; // Self clearing, reads as 0

endpackage

`default_nettype wire

// ==== hw/tmr_cfg_pkg.sv ====
`default_nettype none

package tmr_cfg_pkg;

    // Wide enough for the slowest period, 128 cycles at select 2
    localparam int unsigned PRESCALE_WIDTH = 7;

    localparam int unsigned TICK_EXP_BASE = 9; // Period is 2^(9 - select)

    typedef logic [2:0] clock_sel_t;

    // Selects 0 and 1 belong to the external clock input
    localparam clock_sel_t CLOCK_SEL_MIN = 3'd2;

    // Log2 of the tick period for an internal select
    function automatic int unsigned tick_exp(input clock_sel_t sel);
        return TICK_EXP_BASE - int'(sel);
    endfunction

endpackage

`default_nettype wire
